// ==== verilog.f ====
rtl/datapath_pkg.sv
rtl/fetch.sv
rtl/scoreboard.sv
rtl/regfile.sv
rtl/execute.sv
rtl/sc_datapath.sv
bench/tb_memory.sv
bench/tb_sc_datapath.sv

// ==== Bender.yml ====
package:
  name: sc_datapath

sources:
  - rtl/datapath_pkg.sv
  - rtl/fetch.sv
  - rtl/scoreboard.sv
  - rtl/regfile.sv
  - rtl/execute.sv
  - rtl/sc_datapath.sv
  - target: test
    files:
      - bench/tb_memory.sv
      - bench/tb_sc_datapath.sv

// ==== bench/tb_sc_datapath.sv ====
// Testbench top with test program, reference ISA model, store checker and report
module tb_sc_datapath;
    timeunit 1ns;
    timeprecision 1ps;
    import datapath_pkg::*;

    logic  CLK;
    logic  nrst;
    logic  imemREN;
    word_t imemaddr;
    word_t imemload;
    logic  ihit;
    logic  dmemREN;
    logic  dmemWEN;
    word_t dmemaddr;
    word_t dmemstore;
    word_t dmemload;
    logic  dhit;
    logic  halt;

    word_t program_mem [64];
    int    prog_len;
    word_t exp_addr [$];
    word_t exp_data [$];
    int    stores_seen;
    int    checks;
    int    errors;
    int    timeouts;
    word_t pc_at_halt;

    sc_datapath u_dut (
        .CLK       (CLK),
        .nrst      (nrst),
        .imemREN   (imemREN),
        .imemaddr  (imemaddr),
        .imemload  (imemload),
        .ihit      (ihit),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dmemload  (dmemload),
        .dhit      (dhit),
        .halt      (halt)
    );

    tb_memory u_mem (
        .CLK       (CLK),
        .nrst      (nrst),
        .imemREN   (imemREN),
        .imemaddr  (imemaddr),
        .imemload  (imemload),
        .ihit      (ihit),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dmemload  (dmemload),
        .dhit      (dhit)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // RV32I encodings
    function automatic word_t alu(logic [6:0] f7, logic [2:0] f3, regidx_t rd,
                                  regidx_t rs1, regidx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t addi(regidx_t rd, regidx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic word_t lw(regidx_t rd, regidx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t sw(regidx_t rs2, regidx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch(logic [2:0] f3, regidx_t rs1, regidx_t rs2,
                                     logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic emit(word_t instr);
        program_mem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            program_mem[i] = 32'hffff_ffff;
        end
        // ALU operations with each result stored
        emit(addi(5'd1, 5'd0, 12'd25));
        emit(addi(5'd2, 5'd0, -12'sd7));
        emit(alu(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(alu(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2));
        emit(alu(7'b0000000, 3'b111, 5'd5, 5'd1, 5'd2));
        emit(alu(7'b0000000, 3'b110, 5'd6, 5'd1, 5'd2));
        emit(alu(7'b0000000, 3'b100, 5'd7, 5'd1, 5'd2));
        emit(alu(7'b0000000, 3'b010, 5'd8, 5'd2, 5'd1));
        emit(alu(7'b0000000, 3'b010, 5'd9, 5'd1, 5'd2));
        for (int r = 3; r <= 9; r++) begin
            emit(sw(regidx_t'(r), 5'd0, 12'(32'h40 + 4 * (r - 3))));
        end
        // Dependent chain where every step waits on the one before
        emit(addi(5'd10, 5'd0, 12'd3));
        emit(alu(7'b0000000, 3'b000, 5'd10, 5'd10, 5'd10));
        emit(alu(7'b0000000, 3'b000, 5'd10, 5'd10, 5'd1));
        emit(alu(7'b0100000, 3'b000, 5'd11, 5'd10, 5'd2));
        emit(alu(7'b0000000, 3'b100, 5'd11, 5'd11, 5'd10));
        emit(sw(5'd11, 5'd0, 12'h05c));
        // Store then load back the same word
        emit(addi(5'd12, 5'd0, 12'h060));
        emit(sw(5'd4, 5'd12, 12'd0));
        emit(lw(5'd13, 5'd12, 12'd0));
        emit(addi(5'd13, 5'd13, 12'd1));
        emit(sw(5'd13, 5'd12, 12'd4));
        emit(lw(5'd14, 5'd12, 12'h010));
        emit(addi(5'd14, 5'd14, 12'd1));
        emit(sw(5'd14, 5'd12, 12'd8));
        // Taken BEQ over a store that must never happen
        emit(branch(3'b000, 5'd1, 5'd1, 13'd8));
        emit(sw(5'd1, 5'd0, 12'h07c));
        // BNE loop counting to five
        emit(addi(5'd15, 5'd0, 12'd0));
        emit(addi(5'd16, 5'd0, 12'd5));
        emit(addi(5'd15, 5'd15, 12'd1));
        emit(branch(3'b001, 5'd15, 5'd16, -13'sd4));
        emit(sw(5'd15, 5'd0, 12'h080));
        // x0 stays zero
        emit(addi(5'd0, 5'd0, 12'd99));
        emit(alu(7'b0000000, 3'b000, 5'd0, 5'd1, 5'd1));
        emit(sw(5'd0, 5'd0, 12'h084));
        // BEQ not taken falls through to the store
        emit(branch(3'b000, 5'd1, 5'd2, 13'd8));
        emit(sw(5'd2, 5'd0, 12'h088));
        emit(32'hffff_ffff);
        for (int i = 0; i < 64; i++) begin
            u_mem.prog[i] = program_mem[i];
        end
    endtask

    // Instruction set model collecting the stores in program order
    function automatic void ref_run();
        word_t      regs [32];
        word_t      mem [64];
        word_t      pc;
        word_t      pc_next;
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      addr;
        word_t      res;
        logic [2:0] f3;
        logic       wr;
        logic       done;
        int         steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = u_mem.dmem[i];
        end
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 2000) begin
            instr   = program_mem[pc[7:2]];
            f3      = instr[14:12];
            a       = regs[instr[19:15]];
            b       = regs[instr[24:20]];
            wr      = 1'b0;
            res     = '0;
            pc_next = pc + 32'd4;
            if (instr == 32'hffff_ffff) begin
                done = 1'b1;
            end else begin
                case (instr[6:0])
                    7'b0110011: begin
                        wr = 1'b1;
                        case (f3)
                            3'b000:  res = instr[30] ? a - b : a + b;
                            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            3'b100:  res = a ^ b;
                            3'b110:  res = a | b;
                            3'b111:  res = a & b;
                            default: wr = 1'b0;
                        endcase
                    end
                    7'b0010011: begin
                        wr  = 1'b1;
                        res = a + {{20{instr[31]}}, instr[31:20]};
                    end
                    7'b0000011: begin
                        wr   = 1'b1;
                        addr = a + {{20{instr[31]}}, instr[31:20]};
                        res  = mem[addr[7:2]];
                    end
                    7'b0100011: begin
                        addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                        mem[addr[7:2]] = b;
                        exp_addr.push_back(addr);
                        exp_data.push_back(b);
                    end
                    7'b1100011: begin
                        if ((f3 == 3'b001) ? (a != b) : (a == b)) begin
                            pc_next = pc + {{19{instr[31]}}, instr[31], instr[7],
                                            instr[30:25], instr[11:8], 1'b0};
                        end
                    end
                    default: begin
                    end
                endcase
                if (wr && instr[11:7] != 5'd0) begin
                    regs[instr[11:7]] = res;
                end
            end
            pc = pc_next;
            steps++;
        end
    endfunction

    task automatic check_equal(string what, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Each completed data write against the expected list
    always @(posedge CLK) begin
        if (nrst && halt && dmemREN) begin
            errors++;
            $display("Error: data read from %h at %0t ns after halt", dmemaddr, $time);
        end
        if (nrst && dmemWEN && dhit) begin
            if (halt) begin
                errors++;
                $display("Error: data write to %h at %0t ns after halt", dmemaddr, $time);
            end
            if (dmemaddr == 32'h7c) begin
                errors++;
                $display("Error: store behind the taken BEQ was executed at %0t ns", $time);
            end
            if (stores_seen < exp_addr.size()) begin
                check_equal($sformatf("store %0d address", stores_seen), dmemaddr,
                            exp_addr[stores_seen]);
                check_equal($sformatf("store %0d data", stores_seen), dmemstore,
                            exp_data[stores_seen]);
            end else begin
                errors++;
                $display("Error: unexpected store of %h to %h at %0t ns",
                         dmemstore, dmemaddr, $time);
            end
            stores_seen++;
        end
    end

    task automatic wait_store(int idx, int limit);
        int cycles;
        cycles = 0;
        while (stores_seen <= idx && cycles < limit) begin
            @(negedge CLK);
            cycles++;
        end
        if (stores_seen <= idx) begin
            timeouts++;
            $display("Timeout: store %0d did not arrive within %0d cycles", idx, limit);
        end
    endtask

    task automatic wait_halt(int limit);
        int cycles;
        cycles = 0;
        while (!halt && cycles < limit) begin
            @(negedge CLK);
            cycles++;
        end
        if (!halt) begin
            timeouts++;
            $display("Timeout: halt did not rise within %0d cycles", limit);
        end
    endtask

    initial begin
        nrst        = 1'b0;
        prog_len    = 0;
        stores_seen = 0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        @(posedge CLK);
        load_program();
        ref_run();
        repeat (4) @(posedge CLK);
        nrst <= 1'b1;
        for (int k = 0; k < exp_addr.size(); k++) begin
            wait_store(k, 1000);
        end
        wait_halt(1000);
        check_equal("stores seen at halt", word_t'(stores_seen), word_t'(exp_addr.size()));
        pc_at_halt = imemaddr;
        // Quiet period where the store checker flags any data access
        repeat (50) @(negedge CLK);
        check_equal("halt held", word_t'(halt), 32'd1);
        check_equal("fetch address held after halt", imemaddr, pc_at_halt);
        check_equal("instruction read enable", word_t'(imemREN), 32'd1);
        $display("checks %0d, errors %0d, timeouts %0d, stores %0d of %0d",
                 checks, errors, timeouts, stores_seen, exp_addr.size());
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== bench/tb_memory.sv ====
// Instruction and data memory model with random ihit and dhit latency
module tb_memory (
    input  logic                CLK,
    input  logic                nrst,
    input  logic                imemREN,
    input  datapath_pkg::word_t imemaddr,
    output datapath_pkg::word_t imemload,
    output logic                ihit,
    input  logic                dmemREN,
    input  logic                dmemWEN,
    input  datapath_pkg::word_t dmemaddr,
    input  datapath_pkg::word_t dmemstore,
    output datapath_pkg::word_t dmemload,
    output logic                dhit
);
    timeunit 1ns;
    timeprecision 1ps;
    import datapath_pkg::*;

    word_t      prog [64];
    word_t      dmem [64];
    integer     seed;
    logic [1:0] icnt;
    logic [1:0] dcnt;
    logic       dwait;

    // Array read follows the address, ihit says when the fetch may take it
    assign imemload = imemREN ? prog[imemaddr[7:2]] : '0;

    initial begin
        seed     = 32'hd375_6ecf;
        ihit     = 1'b0;
        dhit     = 1'b0;
        dmemload = '0;
        for (int i = 0; i < 64; i++) begin
            prog[i] = HALT_INSTR;
            dmem[i] = 32'h9e37_79b9 * (i + 1);
        end
    end

    always @(posedge CLK or negedge nrst) begin
        if (!nrst) begin
            ihit     <= 1'b0;
            icnt     <= '0;
            dhit     <= 1'b0;
            dcnt     <= '0;
            dwait    <= 1'b0;
            dmemload <= '0;
        end else begin
            // Gap of 0 to 2 cycles after every instruction hit
            if (icnt != 2'd0) begin
                ihit <= 1'b0;
                icnt <= icnt - 2'd1;
            end else begin
                ihit <= 1'b1;
                icnt <= 2'($unsigned($random(seed)) % 3);
            end

            // One data request at a time, dhit is a single cycle pulse
            if (dhit) begin
                dhit <= 1'b0;
            end else if (dmemREN || dmemWEN) begin
                if (!dwait) begin
                    dwait <= 1'b1;
                    dcnt  <= 2'($unsigned($random(seed)) % 4);
                end else if (dcnt != 2'd0) begin
                    dcnt <= dcnt - 2'd1;
                end else begin
                    dwait <= 1'b0;
                    dhit  <= 1'b1;
                    if (dmemWEN) begin
                        dmem[dmemaddr[7:2]] <= dmemstore;
                    end else begin
                        dmemload <= dmem[dmemaddr[7:2]];
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/sc_datapath.sv ====
// Datapath top with pipeline latches, writeback, sticky halt and memory strobes
module sc_datapath (
    input  logic                CLK,
    input  logic                nrst,
    output logic                imemREN,
    output datapath_pkg::word_t imemaddr,
    input  datapath_pkg::word_t imemload,
    input  logic                ihit,
    output logic                dmemREN,
    output logic                dmemWEN,
    output datapath_pkg::word_t dmemaddr,
    output datapath_pkg::word_t dmemstore,
    input  datapath_pkg::word_t dmemload,
    input  logic                dhit,
    output logic                halt
);
    import datapath_pkg::*;

    word_t   pc;
    logic    freeze;
    logic    ex_taken;
    word_t   ex_target;
    word_t   ex_result;
    logic    ex_stall;
    word_t   wb_data;
    logic    halt_q;

    // Fetch/dispatch latch
    logic    fd_valid;
    word_t   fd_instr;
    word_t   fd_pc;

    // Issue side before the issue/execute latch
    regidx_t rs1;
    regidx_t rs2;
    word_t   rdat1;
    word_t   rdat2;
    logic    iss_valid;
    regidx_t iss_rd;
    logic    iss_wen;
    alu_op_t iss_alu_op;
    br_op_t  iss_br_op;
    mem_op_t iss_mem_op;
    logic    iss_use_imm;
    word_t   iss_imm;
    logic    iss_halt;

    // Issue/execute latch
    logic    ie_valid;
    regidx_t ie_rd;
    logic    ie_wen;
    alu_op_t ie_alu_op;
    br_op_t  ie_br_op;
    mem_op_t ie_mem_op;
    logic    ie_use_imm;
    word_t   ie_imm;
    logic    ie_halt;
    word_t   ie_rdat1;
    word_t   ie_rdat2;
    word_t   ie_pc;

    // Execute/writeback latch
    logic    ew_wen;
    regidx_t ew_rd;
    word_t   ew_result;
    word_t   ew_ldata;
    logic    ew_load;

    assign imemREN  = 1'b1;
    assign imemaddr = pc;
    assign halt     = halt_q;

    fetch u_fetch (
        .CLK      (CLK),
        .nrst     (nrst),
        .ihit     (ihit),
        .freeze   (freeze),
        .redirect (ex_taken),
        .target   (ex_target),
        .halt     (halt_q),
        .pc       (pc)
    );

    // The fetch slot is emptied whenever decode consumes it without a new ihit
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            fd_valid <= 1'b0;
        end else if (ex_taken) begin
            fd_valid <= 1'b0;
        end else if (!freeze) begin
            fd_valid <= ihit;
        end
    end

    always_ff @(posedge CLK) begin
        if (ihit && !freeze) begin
            fd_instr <= imemload;
            fd_pc    <= pc;
        end
    end

    scoreboard u_scoreboard (
        .CLK         (CLK),
        .nrst        (nrst),
        .instr       (fd_instr),
        .instr_valid (fd_valid),
        .flush       (ex_taken),
        .ex_stall    (ex_stall),
        .wb_en       (ew_wen),
        .wb_rd       (ew_rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .freeze      (freeze),
        .iss_valid   (iss_valid),
        .iss_rd      (iss_rd),
        .iss_wen     (iss_wen),
        .iss_alu_op  (iss_alu_op),
        .iss_br_op   (iss_br_op),
        .iss_mem_op  (iss_mem_op),
        .iss_use_imm (iss_use_imm),
        .iss_imm     (iss_imm),
        .iss_halt    (iss_halt)
    );

    regfile u_regfile (
        .CLK   (CLK),
        .nrst  (nrst),
        .wen   (ew_wen),
        .wsel  (ew_rd),
        .wdat  (wb_data),
        .rsel1 (rs1),
        .rsel2 (rs2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            ie_valid <= 1'b0;
            ie_wen   <= 1'b0;
            ie_halt  <= 1'b0;
        end else if (!ex_stall) begin
            ie_valid <= iss_valid;
            ie_wen   <= iss_valid && iss_wen;
            ie_halt  <= iss_valid && iss_halt;
        end
    end

    always_ff @(posedge CLK) begin
        if (!ex_stall) begin
            ie_rd      <= iss_rd;
            ie_alu_op  <= iss_alu_op;
            ie_br_op   <= iss_br_op;
            ie_mem_op  <= iss_mem_op;
            ie_use_imm <= iss_use_imm;
            ie_imm     <= iss_imm;
            ie_rdat1   <= rdat1;
            ie_rdat2   <= rdat2;
            ie_pc      <= fd_pc;
        end
    end

    execute u_execute (
        .CLK       (CLK),
        .nrst      (nrst),
        .valid     (ie_valid),
        .alu_op    (ie_alu_op),
        .br_op     (ie_br_op),
        .mem_op    (ie_mem_op),
        .use_imm   (ie_use_imm),
        .imm       (ie_imm),
        .rdat1     (ie_rdat1),
        .rdat2     (ie_rdat2),
        .cur_pc    (ie_pc),
        .dhit      (dhit),
        .result    (ex_result),
        .taken     (ex_taken),
        .target    (ex_target),
        .stall     (ex_stall),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore)
    );

    // Bubble into writeback while a memory access is outstanding
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            ew_wen <= 1'b0;
            halt_q <= 1'b0;
        end else begin
            ew_wen <= !ex_stall && ie_valid && ie_wen;
            halt_q <= halt_q || (ie_valid && ie_halt);
        end
    end

    // Load data is only valid alongside dhit
    always_ff @(posedge CLK) begin
        if (!ex_stall) begin
            ew_rd     <= ie_rd;
            ew_result <= ex_result;
            ew_ldata  <= dmemload;
            ew_load   <= (ie_mem_op == MEM_LOAD);
        end
    end

    assign wb_data = ew_load ? ew_ldata : ew_result;

endmodule

// ==== rtl/execute.sv ====
// Scalar ALU, branch unit and load/store unit waiting on dhit
module execute (
    input  logic                    CLK,
    input  logic                    nrst,
    input  logic                    valid,
    input  datapath_pkg::alu_op_t   alu_op,
    input  datapath_pkg::br_op_t    br_op,
    input  datapath_pkg::mem_op_t   mem_op,
    input  logic                    use_imm,
    input  datapath_pkg::word_t     imm,
    input  datapath_pkg::word_t     rdat1,
    input  datapath_pkg::word_t     rdat2,
    input  datapath_pkg::word_t     cur_pc,
    input  logic                    dhit,
    output datapath_pkg::word_t     result,
    output logic                    taken,
    output datapath_pkg::word_t     target,
    output logic                    stall,
    output logic                    dmemREN,
    output logic                    dmemWEN,
    output datapath_pkg::word_t     dmemaddr,
    output datapath_pkg::word_t     dmemstore
);
    import datapath_pkg::*;

    word_t       opb;
    word_t       alu_out;
    logic        mem_req;
    exec_state_t state;

    assign opb = use_imm ? imm : rdat2;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_out = rdat1 - opb;
            ALU_AND: alu_out = rdat1 & opb;
            ALU_OR:  alu_out = rdat1 | opb;
            ALU_XOR: alu_out = rdat1 ^ opb;
            ALU_SLT: alu_out = {{(WORD_W-1){1'b0}}, $signed(rdat1) < $signed(opb)};
            default: alu_out = rdat1 + opb;
        endcase
    end

    assign result = alu_out;

    // Branches are predicted not taken so any taken one redirects
    always_comb begin
        case (br_op)
            BR_EQ:   taken = valid && (rdat1 == rdat2);
            BR_NE:   taken = valid && (rdat1 != rdat2);
            default: taken = 1'b0;
        endcase
    end

    assign target = cur_pc + imm;

    // Request comes straight from the issue latch, which holds while stalled
    assign mem_req   = valid && (mem_op != MEM_NONE);
    assign dmemREN   = valid && (mem_op == MEM_LOAD);
    assign dmemWEN   = valid && (mem_op == MEM_STORE);
    assign dmemaddr  = alu_out;
    assign dmemstore = rdat2;
    assign stall     = mem_req && !dhit;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            state <= EX_IDLE;
        end else begin
            case (state)
                EX_IDLE:      state <= (mem_req && !dhit) ? EX_WAIT_DHIT : EX_IDLE;
                EX_WAIT_DHIT: state <= dhit ? EX_IDLE : EX_WAIT_DHIT;
                default:      state <= EX_IDLE;
            endcase
        end
    end

    // A started access keeps its kind until dhit ends it
    mem_req_held: assert property (
        @(posedge CLK) disable iff (!nrst)
        mem_req && !dhit |=> $stable(dmemREN) && $stable(dmemWEN)
    ) else $error("execute: request dropped before dhit");

    // Holding depends on the issue latch in the top level obeying stall
    mem_req_stable: assert property (
        @(posedge CLK) disable iff (!nrst)
        state == EX_WAIT_DHIT |-> $stable(dmemaddr) && $stable(dmemstore)
    ) else $error("execute: request changed while waiting for dhit");

endmodule

// ==== rtl/regfile.sv ====
// 32 entry register file, x0 hardwired to zero, write-through reads
module regfile (
    input  logic                    CLK,
    input  logic                    nrst,
    input  logic                    wen,
    input  datapath_pkg::regidx_t   wsel,
    input  datapath_pkg::word_t     wdat,
    input  datapath_pkg::regidx_t   rsel1,
    input  datapath_pkg::regidx_t   rsel2,
    output datapath_pkg::word_t     rdat1,
    output datapath_pkg::word_t     rdat2
);
    import datapath_pkg::*;

    word_t regs [REG_N];

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdat;
        end
    end

    // Bypass so decode sees the value retiring this cycle
    always_comb begin
        if (rsel1 == '0) begin
            rdat1 = '0;
        end else if (wen && wsel == rsel1) begin
            rdat1 = wdat;
        end else begin
            rdat1 = regs[rsel1];
        end
    end

    always_comb begin
        if (rsel2 == '0) begin
            rdat2 = '0;
        end else if (wen && wsel == rsel2) begin
            rdat2 = wdat;
        end else begin
            rdat2 = regs[rsel2];
        end
    end

endmodule

// ==== rtl/scoreboard.sv ====
// Instruction decode, busy register table and front end freeze
module scoreboard (
    input  logic                    CLK,
    input  logic                    nrst,
    input  datapath_pkg::word_t     instr,
    input  logic                    instr_valid,
    input  logic                    flush,
    input  logic                    ex_stall,
    input  logic                    wb_en,
    input  datapath_pkg::regidx_t   wb_rd,
    output datapath_pkg::regidx_t   rs1,
    output datapath_pkg::regidx_t   rs2,
    output logic                    freeze,
    output logic                    iss_valid,
    output datapath_pkg::regidx_t   iss_rd,
    output logic                    iss_wen,
    output datapath_pkg::alu_op_t   iss_alu_op,
    output datapath_pkg::br_op_t    iss_br_op,
    output datapath_pkg::mem_op_t   iss_mem_op,
    output logic                    iss_use_imm,
    output datapath_pkg::word_t     iss_imm,
    output logic                    iss_halt
);
    import datapath_pkg::*;

    opcode_t          opc;
    logic [2:0]       funct3;
    regidx_t          rd;
    logic             use_rs1;
    logic             use_rs2;
    logic             hazard;
    logic             halt_pend;
    logic [REG_N-1:0] busy;
    logic [REG_N-1:0] busy_set;
    logic [REG_N-1:0] busy_clr;

    assign opc    = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        iss_wen     = 1'b0;
        iss_alu_op  = ALU_ADD;
        iss_br_op   = BR_NONE;
        iss_mem_op  = MEM_NONE;
        iss_use_imm = 1'b0;
        iss_imm     = '0;
        iss_halt    = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        if (instr == HALT_INSTR) begin
            iss_halt = 1'b1;
        end else begin
            case (opc)
                OP_REG: begin
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    iss_wen = (rd != '0);
                    case (funct3)
                        3'b000:  iss_alu_op = instr[30] ? ALU_SUB : ALU_ADD;
                        3'b010:  iss_alu_op = ALU_SLT;
                        3'b100:  iss_alu_op = ALU_XOR;
                        3'b110:  iss_alu_op = ALU_OR;
                        3'b111:  iss_alu_op = ALU_AND;
                        default: iss_wen = 1'b0;
                    endcase
                end
                OP_IMM: begin
                    // ADDI only
                    use_rs1     = 1'b1;
                    iss_wen     = (rd != '0) && (funct3 == 3'b000);
                    iss_use_imm = 1'b1;
                    iss_imm     = {{20{instr[31]}}, instr[31:20]};
                end
                OP_LOAD: begin
                    use_rs1     = 1'b1;
                    iss_wen     = (rd != '0);
                    iss_mem_op  = MEM_LOAD;
                    iss_use_imm = 1'b1;
                    iss_imm     = {{20{instr[31]}}, instr[31:20]};
                end
                OP_STORE: begin
                    use_rs1     = 1'b1;
                    use_rs2     = 1'b1;
                    iss_mem_op  = MEM_STORE;
                    iss_use_imm = 1'b1;
                    iss_imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
                OP_BRANCH: begin
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                    iss_br_op = (funct3 == 3'b001) ? BR_NE : BR_EQ;
                    iss_imm   = {{19{instr[31]}}, instr[31], instr[7],
                                 instr[30:25], instr[11:8], 1'b0};
                end
                default: begin
                    // Anything else retires as a no-op
                end
            endcase
        end
        // Wrong-path instruction does nothing
        if (flush) begin
            iss_wen    = 1'b0;
            iss_br_op  = BR_NONE;
            iss_mem_op = MEM_NONE;
            iss_halt   = 1'b0;
        end
    end

    // A source being written back this cycle is read through the regfile bypass
    always_comb begin
        hazard = 1'b0;
        if (use_rs1 && busy[rs1] && !(wb_en && wb_rd == rs1)) begin
            hazard = 1'b1;
        end
        if (use_rs2 && busy[rs2] && !(wb_en && wb_rd == rs2)) begin
            hazard = 1'b1;
        end
        // Only one writer in flight per register
        if (iss_wen && busy[rd]) begin
            hazard = 1'b1;
        end
    end

    assign freeze    = (instr_valid && hazard) || ex_stall || halt_pend;
    assign iss_valid = instr_valid && !flush && !freeze;
    assign iss_rd    = rd;

    always_comb begin
        busy_set = '0;
        busy_clr = '0;
        if (iss_valid && iss_wen) begin
            busy_set[rd] = 1'b1;
        end
        if (wb_en) begin
            busy_clr[wb_rd] = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy      <= '0;
            halt_pend <= 1'b0;
        end else begin
            // x0 never tracked
            busy      <= ((busy & ~busy_clr) | busy_set) & ~REG_N'(1);
            halt_pend <= halt_pend || (iss_valid && iss_halt);
        end
    end

    // Writeback must never retire a register that issue is claiming again
    busy_no_race: assert property (
        @(posedge CLK) disable iff (!nrst)
        (busy_set & busy_clr) == '0
    ) else $error("scoreboard: busy bit set and cleared together");

    // The fetch/dispatch latch has to hold a frozen instruction
    frozen_instr_held: assert property (
        @(posedge CLK) disable iff (!nrst)
        instr_valid && freeze && !flush |=> instr_valid && $stable(instr)
    ) else $error("scoreboard: frozen instruction changed");

endmodule

// ==== rtl/fetch.sv ====
// Program counter with freeze, branch redirect and halt
module fetch (
    input  logic                CLK,
    input  logic                nrst,
    input  logic                ihit,
    input  logic                freeze,
    input  logic                redirect,
    input  datapath_pkg::word_t target,
    input  logic                halt,
    output datapath_pkg::word_t pc
);
    import datapath_pkg::*;

    word_t pc_q;

    assign pc = pc_q;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc_q <= '0;
        end else if (halt) begin
            // Machine stopped, hold the last pc
            pc_q <= pc_q;
        end else if (redirect) begin
            // Taken branch overrides any freeze
            pc_q <= target;
        end else if (ihit && !freeze) begin
            pc_q <= pc_q + word_t'(4);
        end
    end

    // Targets come from execute, so a bad immediate would show up here
    pc_aligned: assert property (
        @(posedge CLK) disable iff (!nrst)
        pc_q[1:0] == 2'b00
    ) else $error("fetch: pc %h not word aligned", pc_q);

endmodule

// ==== rtl/datapath_pkg.sv ====
// Shared widths, opcodes, control enums and execute state type for the scalar datapath
package datapath_pkg;

    localparam int WORD_W = 32;
    localparam int REG_N  = 32;

    // Data and address word
    typedef logic [WORD_W-1:0] word_t;

    // Register index
    typedef logic [$clog2(REG_N)-1:0] regidx_t;

    // All ones, outside every RV32I encoding
    localparam word_t HALT_INSTR = '1;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_t;

    // Scalar ALU operations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    // Branch comparisons
    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } br_op_t;

    // Scalar memory access kind
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    // Load/store unit state
    typedef enum logic {
        EX_IDLE,
        EX_WAIT_DHIT
    } exec_state_t;

endpackage
